// ==== logic/rv_hazard_config.svh ====
`ifndef RV_HAZARD_CONFIG_SVH
`define RV_HAZARD_CONFIG_SVH

// Build options of the hazard-control block

// Set to 1 when a forwarding unit sits in front of EX
// The detector then stalls only where a result cannot be forwarded in time
`define RV_FWD 1

// Set to 1 when the register file returns a same-cycle write on a read
// A producer already in WB can then never cause a hazard
`define RV_FWD_REGFILE 1

// Memory styles for the data side
// With BRAM the load result comes out of the registered read port in WB
`define RV_MEM_TYPE_SRAM 0
`define RV_MEM_TYPE_BRAM 1
`define RV_MEM_TYPE `RV_MEM_TYPE_BRAM

// Cycles an M-extension instruction occupies EX, including the cycle it leaves
// Values below 1 are not meaningful
`define RV_M_OP_CYCLES 4

`endif

// ==== logic/rv_hazard_pkg.sv ====
`default_nettype none

package rv_hazard_pkg;

  // Where the value written to rd comes from
  // Only the load, CSR and M kinds matter for hazards, the rest forward early
  typedef enum logic [2:0] {
    RES_ALU = 3'd0,
    RES_MEM = 3'd1,
    RES_CSR = 3'd2,
    RES_M   = 3'd3,
    RES_PC4 = 3'd4
  } res_src_e;

  // Selection of the next PC as resolved by the front end and EX
  typedef enum logic [1:0] {
    PC_SEL_SEQ       = 2'd0,
    PC_SEL_PREDICTED = 2'd1,
    PC_SEL_REDIRECT  = 2'd2
  } pc_sel_e;

  // Decoded instruction as it arrives from fetch and sits in ID
  // The source fields are needed only in ID
  typedef struct packed {
    logic     valid;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic     rs1_used;
    logic     rs2_used;
    logic [4:0] rd;
    logic     reg_write;
    res_src_e res_src;
  } dec_info_t;

  // Record carried from EX onwards
  // Only the destination side survives
  typedef struct packed {
    logic       valid;
    logic [4:0] rd;
    logic       reg_write;
    res_src_e   res_src;
  } stage_info_t;

  // Stall and flush controls for the PC and the four pipeline registers
  typedef struct packed {
    logic pc_stall;
    logic if_id_stall;
    logic if_id_flush;
    logic id_ex_stall;
    logic id_ex_flush;
    logic ex_mem_stall;
    logic ex_mem_flush;
    logic mem_wb_stall;
  } hazard_ctrl_t;

endpackage

`default_nettype wire

// ==== logic/rv_hazard_detect.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_hazard_config.svh"

module rv_hazard_detect
  import rv_hazard_pkg::*;
(
  input  dec_info_t    id_rec,
  input  stage_info_t  ex_rec,
  input  stage_info_t  mem_rec,
  input  stage_info_t  wb_rec,
  input  logic         op_active_ex,
  input  pc_sel_e      pc_sel,
  input  logic         mispredicted_mem,
  input  logic         btb_pred_taken,
  input  logic         ras_pred_taken,
  input  logic         halt,
  output hazard_ctrl_t ctrl
);

  // True when the instruction in ID reads a register that a later stage
  // is about to write
  // Writes to x0 are dropped by the register file, so they never conflict
  function automatic logic reads_dest(input dec_info_t rd_side, input stage_info_t wr_side);
    logic writes;
    logic rs1_hit;
    logic rs2_hit;
    writes  = wr_side.valid && wr_side.reg_write && (wr_side.rd != 5'd0);
    rs1_hit = rd_side.rs1_used && (rd_side.rs1 == wr_side.rd);
    rs2_hit = rd_side.rs2_used && (rd_side.rs2 == wr_side.rd);
    return rd_side.valid && writes && (rs1_hit || rs2_hit);
  endfunction

  // Result kinds that the forwarding unit cannot supply before WB
  // An SRAM load is ready in MEM and forwards like an ALU result
  function automatic logic late_result(input stage_info_t wr_side);
    logic late_load;
    late_load = (wr_side.res_src == RES_MEM) && (`RV_MEM_TYPE == `RV_MEM_TYPE_BRAM);
    return late_load || (wr_side.res_src == RES_CSR) || (wr_side.res_src == RES_M);
  endfunction

  logic ex_hit;
  logic mem_hit;
  logic wb_hit;
  logic data_hazard;
  logic redirect;
  logic predicted;
  logic stall_off;
  logic front_stall;
  logic pred_flush;

  // Raw register matches against each producing stage
  always_comb begin
    ex_hit  = reads_dest(id_rec, ex_rec);
    mem_hit = reads_dest(id_rec, mem_rec);
    // A bypassing register file already hands the WB value to ID
    wb_hit  = (`RV_FWD_REGFILE == 0) && reads_dest(id_rec, wb_rec);
  end

  // Decide which matches really cost a stall
  always_comb begin
    if (`RV_FWD != 0) begin
      // ALU results in EX and MEM are forwarded, only late results wait
      data_hazard = (ex_hit && late_result(ex_rec)) ||
                    (mem_hit && late_result(mem_rec)) ||
                    wb_hit;
    end else begin
      // Without forwarding the reader waits until the writer has left WB
      data_hazard = ex_hit || mem_hit || wb_hit;
    end
  end

  always_comb begin
    redirect  = (pc_sel == PC_SEL_REDIRECT);
    predicted = (pc_sel == PC_SEL_PREDICTED);

    // A redirect throws away the stalled reader anyway, so holding it is pointless
    stall_off   = redirect || mispredicted_mem;
    front_stall = (data_hazard || op_active_ex) && !stall_off;

    // The BTB steers the PC before the fall-through is fetched
    // A RAS or static prediction is made from ID, so the fetched slot is wrong
    // Only drop it when ID actually hands its instruction on this cycle
    pred_flush = predicted && (!btb_pred_taken || ras_pred_taken) &&
                 !data_hazard && !op_active_ex && !halt;
  end

  // Stalls hold a stage, halt holds all of them
  // The back half only waits on a busy EX, data hazards get a bubble instead
  always_comb begin
    ctrl.pc_stall     = front_stall || halt;
    ctrl.if_id_stall  = front_stall || halt;
    ctrl.id_ex_stall  = op_active_ex || halt;
    ctrl.ex_mem_stall = op_active_ex || halt;
    ctrl.mem_wb_stall = op_active_ex || halt;

    // Wrong-path work younger than the branch is removed
    // A mispredict is resolved in MEM, so EX holds wrong-path work as well
    ctrl.if_id_flush  = redirect || mispredicted_mem || pred_flush;
    // The bubble behind a waiting reader is not inserted while EX is busy,
    // as that would wipe out the multi-cycle instruction
    ctrl.id_ex_flush  = (data_hazard && !op_active_ex) || redirect || mispredicted_mem;
    ctrl.ex_mem_flush = mispredicted_mem;
  end

endmodule

`default_nettype wire

// ==== logic/rv_stage_track.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_stage_track
  import rv_hazard_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  dec_info_t    fetch,
  input  hazard_ctrl_t ctrl,
  output dec_info_t    id_rec,
  output stage_info_t  ex_rec,
  output stage_info_t  mem_rec,
  output stage_info_t  wb_rec,
  output logic         ex_load
);

  // The record entering EX keeps only what the later stages compare against
  stage_info_t id_narrow;

  assign id_narrow = '{
    valid:     id_rec.valid,
    rd:        id_rec.rd,
    reg_write: id_rec.reg_write,
    res_src:   id_rec.res_src
  };

  // ID/EX takes a new record on a flush as well, even if that record is a bubble
  assign ex_load = ctrl.id_ex_flush || !ctrl.id_ex_stall;

  // IF/ID register
  // In every stage a flush wins over a stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_rec <= '0;
    end else if (ctrl.if_id_flush) begin
      id_rec <= '0;
    end else if (!ctrl.if_id_stall) begin
      id_rec <= fetch;
    end
  end

  // ID/EX register
  // An empty record is the bubble for a load-use stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_rec <= '0;
    end else if (ctrl.id_ex_flush) begin
      ex_rec <= '0;
    end else if (!ctrl.id_ex_stall) begin
      ex_rec <= id_narrow;
    end
  end

  // EX/MEM register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_rec <= '0;
    end else if (ctrl.ex_mem_flush) begin
      mem_rec <= '0;
    end else if (!ctrl.ex_mem_stall) begin
      mem_rec <= ex_rec;
    end
  end

  // MEM/WB register
  // Nothing after MEM can be on a wrong path, so there is no flush here
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_rec <= '0;
    end else if (!ctrl.mem_wb_stall) begin
      wb_rec <= mem_rec;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_mdiv_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_hazard_config.svh"

module rv_mdiv_timer
  import rv_hazard_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  stage_info_t ex_rec,
  input  logic        ex_load,
  output logic        op_active_ex
);

  // Enough bits to reach the last busy cycle and never fewer than one
  localparam int CNT_W = (`RV_M_OP_CYCLES > 1) ? $clog2(`RV_M_OP_CYCLES) : 1;
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`RV_M_OP_CYCLES - 1);

  logic [CNT_W-1:0] count;
  logic             m_in_ex;

  assign m_in_ex = ex_rec.valid && (ex_rec.res_src == RES_M);

  // Busy in every cycle but the final one, when the result is complete
  // and the whole pipeline may step forward again
  assign op_active_ex = m_in_ex && (count != LAST_CNT);

  // The count is zero in the first cycle of every new EX record
  // It only moves while an M instruction is still working
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (ex_load) begin
      count <= '0;
    end else if (op_active_ex) begin
      count <= count + CNT_W'(1);
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_hazard_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_hazard_top
  import rv_hazard_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  dec_info_t    fetch,
  input  pc_sel_e      pc_sel,
  input  logic         mispredicted_mem,
  input  logic         btb_pred_taken,
  input  logic         ras_pred_taken,
  input  logic         halt,
  output hazard_ctrl_t ctrl,
  output stage_info_t  wb
);

  dec_info_t   id_rec;
  stage_info_t ex_rec;
  stage_info_t mem_rec;
  logic        ex_load;
  logic        op_active_ex;

  // Pipeline registers, steered by the controls from the detector
  // The record leaving WB is the register-file write request
  rv_stage_track u_stage_track (
    .clk     (clk),
    .rst_n   (rst_n),
    .fetch   (fetch),
    .ctrl    (ctrl),
    .id_rec  (id_rec),
    .ex_rec  (ex_rec),
    .mem_rec (mem_rec),
    .wb_rec  (wb),
    .ex_load (ex_load)
  );

  // Busy flag for a multi-cycle M instruction in EX
  rv_mdiv_timer u_mdiv_timer (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_rec       (ex_rec),
    .ex_load      (ex_load),
    .op_active_ex (op_active_ex)
  );

  // Controls are combinational from the registered records, so the loop
  // through the tracker is broken by its flops
  rv_hazard_detect u_hazard_detect (
    .id_rec           (id_rec),
    .ex_rec           (ex_rec),
    .mem_rec          (mem_rec),
    .wb_rec           (wb),
    .op_active_ex     (op_active_ex),
    .pc_sel           (pc_sel),
    .mispredicted_mem (mispredicted_mem),
    .btb_pred_taken   (btb_pred_taken),
    .ras_pred_taken   (ras_pred_taken),
    .halt             (halt),
    .ctrl             (ctrl)
  );

endmodule

`default_nettype wire

// ==== bench/rv_hazard_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_hazard_tb
  import rv_hazard_pkg::*;
();

  logic         clk;
  logic         rst_n;
  dec_info_t    fetch;
  pc_sel_e      pc_sel;
  logic         mispredicted_mem;
  logic         btb_pred_taken;
  logic         ras_pred_taken;
  logic         halt;
  hazard_ctrl_t ctrl;
  stage_info_t  wb;

  // Per-cycle stimulus and expected results, one entry for each case line
  // The strobes are packed as mispredicted_mem, btb, ras, halt
  string        name_q[$];
  dec_info_t    fetch_q[$];
  pc_sel_e      sel_q[$];
  logic [3:0]   pin_q[$];
  hazard_ctrl_t ctrl_q[$];
  stage_info_t  wb_q[$];

  int ctrl_errors = 0;
  int wb_errors = 0;
  int other_errors = 0;
  int cycle_count = 0;
  int cycle_limit = 20;

  rv_hazard_top dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch            (fetch),
    .pc_sel           (pc_sel),
    .mispredicted_mem (mispredicted_mem),
    .btb_pred_taken   (btb_pred_taken),
    .ras_pred_taken   (ras_pred_taken),
    .halt             (halt),
    .ctrl             (ctrl),
    .wb               (wb)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // Stops a run that keeps going past the length of the case list
  initial begin
    @(posedge clk);
    while (cycle_count <= cycle_limit) begin
      @(posedge clk);
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("SIMULATION FAILED");
    $finish;
  end

  function automatic string stage_str(input stage_info_t rec);
    return $sformatf("valid=%0b rd=%0d we=%0b src=%0d",
                     rec.valid, rec.rd, rec.reg_write, rec.res_src);
  endfunction

  task automatic check_ctrl(input string name, input hazard_ctrl_t exp, input hazard_ctrl_t act);
    if (act !== exp) begin
      ctrl_errors++;
      $display("Fail %s: ctrl expected %b, actual %b", name, exp, act);
    end
  endtask

  // An invalid expected record stands for a bubble, so only its valid bit counts
  task automatic check_wb(input string name, input stage_info_t exp, input stage_info_t act);
    if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
      wb_errors++;
      $display("Fail %s: wb expected %s, actual %s", name, stage_str(exp), stage_str(act));
    end
  endtask

  task automatic load_cases();
    int         fd;
    int         n;
    string      line;
    string      name;
    int         f[8];
    int         p[5];
    int         w[4];
    logic [7:0] cbits;
    fd = $fopen("bench/rv_hazard_cases.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open the cases file bench/rv_hazard_cases.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // Blank lines and lines opening with a hash hold no cycle
      if (line.len() < 2 || line.getc(0) == 8'h23) continue;
      n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %b %d %d %d %d",
                  name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                  p[0], p[1], p[2], p[3], p[4], cbits, w[0], w[1], w[2], w[3]);
      if (n != 19) begin
        other_errors++;
        $display("Could not read this case line: %s", line);
        continue;
      end
      name_q.push_back(name);
      fetch_q.push_back(dec_info_t'{valid: f[0][0], rs1: f[1][4:0], rs2: f[2][4:0],
                                    rs1_used: f[3][0], rs2_used: f[4][0], rd: f[5][4:0],
                                    reg_write: f[6][0], res_src: res_src_e'(f[7][2:0])});
      sel_q.push_back(pc_sel_e'(p[0][1:0]));
      pin_q.push_back({p[1][0], p[2][0], p[3][0], p[4][0]});
      ctrl_q.push_back(hazard_ctrl_t'(cbits));
      wb_q.push_back(stage_info_t'{valid: w[0][0], rd: w[1][4:0], reg_write: w[2][0],
                                   res_src: res_src_e'(w[3][2:0])});
    end
    $fclose(fd);
  endtask

  initial begin
    rst_n            = 1'b0;
    fetch            = '0;
    pc_sel           = PC_SEL_SEQ;
    mispredicted_mem = 1'b0;
    btb_pred_taken   = 1'b0;
    ras_pred_taken   = 1'b0;
    halt             = 1'b0;
    load_cases();
    if (name_q.size() == 0) begin
      other_errors++;
      $display("No test cases were read, nothing was checked");
    end
    cycle_limit = name_q.size() + 20;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Inputs change 2 ns after an edge, outputs are sampled 1 ns before the next one
    foreach (name_q[i]) begin
      fetch  = fetch_q[i];
      pc_sel = sel_q[i];
      {mispredicted_mem, btb_pred_taken, ras_pred_taken, halt} = pin_q[i];
      #17;
      check_ctrl(name_q[i], ctrl_q[i], ctrl);
      check_wb(name_q[i], wb_q[i], wb);
      @(posedge clk);
      #2;
    end
    $display("Errors: ctrl %0d, wb %0d, other %0d", ctrl_errors, wb_errors, other_errors);
    if (ctrl_errors + wb_errors + other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/rv_hazard_cases.txt ====
# name | fetch: valid rs1 rs2 rs1_used rs2_used rd we src | pc_sel mispred btb ras halt
# ctrl: pc ifid_s ifid_f idex_s idex_f exmem_s exmem_f memwb_s | wb: valid rd we src
reset_idle 0 0  0 0 0 0  0 0  0 0 0 0 0  00000000  0 0  0 0
alu_raw    1 1  2 1 1 5  1 0  0 0 0 0 0  00000000  0 0  0 0
alu_raw    1 5  3 1 1 6  1 0  0 0 0 0 0  00000000  0 0  0 0
alu_raw    1 7  0 1 0 0  1 1  0 0 0 0 0  00000000  0 0  0 0
alu_raw    1 0  9 1 1 10 1 0  0 0 0 0 0  00000000  0 0  0 0
load_use   1 1  0 1 0 11 1 1  0 0 0 0 0  00000000  1 5  1 0
load_use   1 11 2 1 1 12 1 0  0 0 0 0 0  00000000  1 6  1 0
load_use   1 3  4 1 1 13 1 0  0 0 0 0 0  11001000  1 0  1 1
load_use   1 3  4 1 1 13 1 0  0 0 0 0 0  11001000  1 10 1 0
load_use   1 3  4 1 1 13 1 0  0 0 0 0 0  00000000  1 11 1 1
m_op       1 1  2 1 1 14 1 3  0 0 0 0 0  00000000  0 0  0 0
m_op       1 5  6 1 1 15 1 0  0 0 0 0 0  00000000  0 0  0 0
m_op       1 7  8 1 1 16 1 0  0 0 0 0 0  11010101  1 12 1 0
m_op       1 7  8 1 1 16 1 0  0 0 0 0 0  11010101  1 12 1 0
m_op       1 7  8 1 1 16 1 0  0 0 0 0 0  11010101  1 12 1 0
m_op       1 7  8 1 1 16 1 0  0 0 0 0 0  00000000  1 12 1 0
m_op       1 1  0 1 0 17 1 1  0 0 0 0 0  00000000  1 13 1 0
redirect   1 17 0 1 0 18 1 0  0 0 0 0 0  00000000  1 14 1 3
redirect   1 2  3 1 1 19 1 0  2 0 0 0 0  00101000  1 15 1 0
redirect   1 4  0 1 0 20 1 0  0 0 0 0 0  00000000  1 16 1 0
redirect   1 5  0 1 0 21 1 0  0 0 0 0 0  00000000  1 17 1 1
mispredict 1 6  0 1 0 22 1 0  0 0 0 0 0  00000000  0 0  0 0
mispredict 1 7  0 1 0 23 1 0  0 1 0 0 0  00101010  0 0  0 0
mispredict 1 8  0 1 0 24 1 0  0 0 0 0 0  00000000  1 20 1 0
predict    1 9  0 1 0 25 1 0  1 0 1 0 0  00000000  0 0  0 0
predict    1 10 0 1 0 26 1 0  1 0 0 1 0  00100000  0 0  0 0
predict    1 11 0 1 0 27 1 0  0 0 0 0 0  00000000  0 0  0 0
halt       1 12 0 1 0 28 1 0  0 0 0 0 1  11010101  1 24 1 0
halt       1 12 0 1 0 28 1 0  0 0 0 0 1  11010101  1 24 1 0
halt       1 12 0 1 0 28 1 0  0 0 0 0 0  00000000  1 24 1 0
halt       0 0  0 0 0 0  0 0  0 0 0 0 0  00000000  1 25 1 0
halt       0 0  0 0 0 0  0 0  0 0 0 0 0  00000000  0 0  0 0
halt       0 0  0 0 0 0  0 0  0 0 0 0 0  00000000  1 27 1 0
halt       0 0  0 0 0 0  0 0  0 0 0 0 0  00000000  1 28 1 0

// ==== compile.f ====
+incdir+logic
logic/rv_hazard_pkg.sv
logic/rv_hazard_detect.sv
logic/rv_stage_track.sv
logic/rv_mdiv_timer.sv
logic/rv_hazard_top.sv
bench/rv_hazard_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module rv_hazard_tb -f compile.f -o rv_hazard_sim \
  > sim.log 2>&1 \
  && ./obj_dir/rv_hazard_sim >> sim.log 2>&1 \
  || echo "Build or simulation run did not complete" >> sim.log
cat sim.log
grep -q "^SIMULATION PASSED$" sim.log && exit 0 || exit 1
